// File: x86_pkg.sv
package x86_pkg;

  // ----------------------------------------------------------
  // Widths and base types
  // ----------------------------------------------------------
  localparam int addr_w = 20;            // 1 MB real-mode space

  typedef logic [31:0] word_t;           // Register and operand word
  typedef logic [15:0] half_t;           // Segment, ip, 16-bit ea
  typedef logic [7:0]  byte_t;           // One bus byte
  typedef logic [8:0]  opcode_t;         // Bit 8 set after 0Fh

  // Prefix bytes
  localparam byte_t pfx_0f    = 8'h0f;   // Opcode extension
  localparam byte_t pfx_es    = 8'h26;
  localparam byte_t pfx_cs    = 8'h2e;
  localparam byte_t pfx_ss    = 8'h36;
  localparam byte_t pfx_ds    = 8'h3e;
  localparam byte_t pfx_osize = 8'h66;   // Toggles 16/32 operands
  localparam byte_t pfx_asize = 8'h67;   // Toggles 16/32 addressing
  localparam byte_t pfx_lock  = 8'hf0;
  localparam byte_t pfx_fs    = 8'h64;   // fs/gs not implemented
  localparam byte_t pfx_gs    = 8'h65;
  localparam byte_t pfx_repnz = 8'hf2;
  localparam byte_t pfx_repz  = 8'hf3;

  // ----------------------------------------------------------
  // Sequencer and size encodings
  // ----------------------------------------------------------
  typedef enum logic [2:0] {
    st_init,                             // Clear per-instruction state
    st_fetch,                            // Prefixes and opcode
    st_modrm_rd,                         // ModRM byte
    st_modrm_op,                         // Wait disp, pick operands
    st_modrm_mem,                        // Memory operand read
    st_issue                             // Record valid
  } seq_state_t;

  typedef logic [1:0] imm_size_t;        // Byte count minus one

  typedef enum logic [1:0] {
    sz8  = 2'd0,
    sz16 = 2'd1,
    sz32 = 2'd2
  } op_size_t;

  typedef struct packed {
    logic osize;
    logic asize;
    logic repz;
    logic repnz;
    logic seg_override;
  } prefix_t;

  // Segment registers, in encoding order
  typedef struct packed {
    half_t es;
    half_t cs;
    half_t ss;
    half_t ds;
  } sreg_t;

  typedef struct packed {
    opcode_t     opcode;
    byte_t       modrm;
    logic        has_modrm;
    logic        mem_operand;            // r/m names memory
    logic        addr32;                 // 67h seen, no operand fetch
    prefix_t     prefixes;
    half_t       segment;
    half_t       ea;
    word_t       op1;
    word_t       op2;
    half_t       ip_next;
    logic [14:0] pad;
  } decoded_t;

  // Write-back request
  typedef struct packed {
    logic       sreg;                    // 1 = es/cs/ss/ds by rnum[1:0]
    logic [2:0] rnum;
    op_size_t   size;
    word_t      data;
  } wb_t;

  // ModRM follows this opcode byte?
  function automatic logic needs_modrm(input byte_t op, input logic ext);
    logic m;
    if (ext) begin
      casez (op)                         // 0Fh table lists the exceptions
        8'b0000_01??,                    // 04-07
        8'b0000_10??,                    // 08-0B
        8'b0010_01?1,                    // 25, 27
        8'b0011_10?1,                    // 39, 3B
        8'b0011_0???,                    // 30-37
        8'b0011_11??,                    // 3C-3F
        8'b1000_????,                    // Jcc near
        8'b1010_?00?,                    // Push/pop fs, gs
        8'b1010_?010,
        8'b1010_011?,
        8'b1100_1???,                    // BSWAP
        8'h0c, 8'h0e, 8'hff,
        8'h77, 8'h7a, 8'h7b: m = 1'b0;
        default:             m = 1'b1;
      endcase
    end else begin
      casez (op)
        8'b00??_?0??,                    // ALU r/m forms
        8'b1000_????,                    // 80-8F
        8'b1100_01??,                    // C4-C7
        8'b1101_00??,                    // Shift group
        8'b1101_1???,                    // FPU escape
        8'b1111_?11?,                    // F6-F7, FE-FF
        8'h62, 8'h63, 8'h69,
        8'h6b, 8'hc0, 8'hc1: m = 1'b1;
        default:             m = 1'b0;
      endcase
    end
    return m;
  endfunction

endpackage

// File: modrm_ea_unit.sv
`timescale 1ns/1ps

module modrm_ea_unit (
  input  x86_pkg::byte_t     modrm,
  input  x86_pkg::half_t     bx,
  input  x86_pkg::half_t     bp,
  input  x86_pkg::half_t     si,
  input  x86_pkg::half_t     di,
  output x86_pkg::half_t     base_ea,
  output logic               use_ss,
  output logic               disp_present,
  output x86_pkg::imm_size_t disp_size
);

  logic [1:0] mod_f;
  logic [2:0] rm;

  assign mod_f = modrm[7:6];
  assign rm    = modrm[2:0];

  // 16-bit base table, wraps at 64K
  always_comb begin
    case (rm)
      3'b000:  base_ea = bx + si;
      3'b001:  base_ea = bx + di;
      3'b010:  base_ea = bp + si;
      3'b011:  base_ea = bp + di;
      3'b100:  base_ea = si;
      3'b101:  base_ea = di;
      3'b110:  base_ea = (mod_f == 2'b00) ? 16'h0000 : bp; // Direct disp16 at mod 00
      default: base_ea = bx;
    endcase
  end

  // ----------------------------------------------------------
  // Default segment and displacement length
  // ----------------------------------------------------------
  // [bp+si], [bp+di] and [bp+disp] go to ss
  assign use_ss = (mod_f != 2'b11) &&
                  ((rm[2:1] == 2'b01) || (rm == 3'b110 && mod_f != 2'b00));

  assign disp_present = (mod_f == 2'b01) || (mod_f == 2'b10) ||
                        (mod_f == 2'b00 && rm == 3'b110);

  assign disp_size = (mod_f == 2'b01) ? 2'd0 : 2'd1; // disp8 or disp16

endmodule

// File: imm_loader.sv
`timescale 1ns/1ps

module imm_loader (
  input  logic               clk25,
  input  logic               rst_n,
  input  x86_pkg::byte_t     din,
  input  logic               load_start,
  input  x86_pkg::imm_size_t load_size,
  output logic               load_byte,
  output logic               load_done,
  output x86_pkg::word_t     load_word
);

  import x86_pkg::*;

  logic      active;
  imm_size_t phase;                      // Byte index being taken
  imm_size_t size;                       // Last index

  assign load_byte = active;             // One byte per cycle while busy

  always_ff @(posedge clk25 or negedge rst_n) begin
    if (!rst_n) begin
      active    <= 1'b0;
      phase     <= '0;
      size      <= '0;
      load_done <= 1'b0;
    end else begin
      load_done <= 1'b0;                 // Single-cycle strobe
      if (load_start) begin
        active <= 1'b1;
        phase  <= '0;
        size   <= load_size;
      end else if (active) begin
        if (phase == size) begin
          active    <= 1'b0;
          load_done <= 1'b1;
        end else begin
          phase <= phase + 2'd1;
        end
      end
    end
  end

  // Little endian, zero above the loaded bytes
  always_ff @(posedge clk25) begin
    if (load_start)  load_word <= '0;
    else if (active) load_word[{phase, 3'b000} +: 8] <= din;
  end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic              clk25,
  input  logic              rst_n,
  input  logic [2:0]        rd_a,
  input  logic [2:0]        rd_b,
  input  x86_pkg::op_size_t rd_size,
  output x86_pkg::word_t    val_a,
  output x86_pkg::word_t    val_b,
  input  logic              wb_valid,
  input  x86_pkg::wb_t      wb,
  output x86_pkg::sreg_t    sregs,
  output x86_pkg::half_t    bx,
  output x86_pkg::half_t    bp,
  output x86_pkg::half_t    si,
  output x86_pkg::half_t    di
);

  import x86_pkg::*;

  word_t gpr [8];                        // eax ecx edx ebx esp ebp esi edi

  // Sized view, codes 4..7 at 8 bits alias AH..BH
  function automatic word_t sized_view(input word_t full, input word_t alias_w,
                                       input logic hi_byte, input op_size_t size);
    word_t v;
    case (size)
      sz32:    v = full;
      sz16:    v = {16'h0000, full[15:0]};
      default: v = hi_byte ? {24'h0, alias_w[15:8]} : {24'h0, full[7:0]};
    endcase
    return v;
  endfunction

  // ----------------------------------------------------------
  // Read ports
  // ----------------------------------------------------------
  assign val_a = sized_view(gpr[rd_a], gpr[{1'b0, rd_a[1:0]}], rd_a[2], rd_size);
  assign val_b = sized_view(gpr[rd_b], gpr[{1'b0, rd_b[1:0]}], rd_b[2], rd_size);

  // Address bases for ModRM
  assign bx = gpr[3][15:0];
  assign bp = gpr[5][15:0];
  assign si = gpr[6][15:0];
  assign di = gpr[7][15:0];

  // ----------------------------------------------------------
  // Write-back port
  // ----------------------------------------------------------
  always_ff @(posedge clk25 or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 8; i++) begin
        gpr[i] <= '0;
      end
      sregs <= '0;
    end else if (wb_valid) begin
      if (wb.sreg) begin
        case (wb.rnum[1:0])
          2'd0:    sregs.es <= wb.data[15:0];
          2'd1:    sregs.cs <= wb.data[15:0];
          2'd2:    sregs.ss <= wb.data[15:0];
          default: sregs.ds <= wb.data[15:0];
        endcase
      end else begin
        case (wb.size)
          sz32: gpr[wb.rnum]       <= wb.data;
          sz16: gpr[wb.rnum][15:0] <= wb.data[15:0]; // Upper half kept
          default: begin
            if (wb.rnum[2])
              gpr[{1'b0, wb.rnum[1:0]}][15:8] <= wb.data[7:0]; // AH..BH
            else
              gpr[wb.rnum][7:0] <= wb.data[7:0];               // AL..BL
          end
        endcase
      end
    end
  end

endmodule

// File: instr_sequencer.sv
`timescale 1ns/1ps

module instr_sequencer (
  input  logic                       clk25,
  input  logic                       rst_n,
  input  x86_pkg::byte_t             din,
  output logic [2:0]                 rd_a,       // r/m field
  output logic [2:0]                 rd_b,       // reg field
  output x86_pkg::op_size_t          rd_size,
  input  x86_pkg::word_t             val_a,
  input  x86_pkg::word_t             val_b,
  input  x86_pkg::sreg_t             sregs,
  output x86_pkg::byte_t             modrm,
  input  x86_pkg::half_t             base_ea,
  input  logic                       use_ss,
  input  x86_pkg::imm_size_t         disp_size,
  input  logic                       disp_present,
  output logic                       load_start,
  output x86_pkg::imm_size_t         load_size,
  input  logic                       load_byte,
  input  logic                       load_done,
  input  x86_pkg::word_t             load_word,
  output logic [x86_pkg::addr_w-1:0] address,
  output logic                       dec_valid,
  output x86_pkg::decoded_t          dec
);

  import x86_pkg::*;

  seq_state_t state;
  prefix_t    pfx;
  opcode_t    opcode;
  byte_t      modrm_q;                   // Held ModRM byte
  logic       has_modrm;
  logic       direction;                 // Opcode bit 1 set when reg is op1
  logic       bitsize;                   // Opcode bit 0 clear for byte ops
  half_t      ip;
  half_t      segment;
  half_t      ea;
  half_t      ea_save;                   // Final ea while ea walks memory
  half_t      ea_calc;
  word_t      op1;
  word_t      op2;
  logic       is_prefix;
  logic       mem_form;
  logic       disp_ready;
  logic       am;                        // Selects segment:ea over cs:ip

  // ----------------------------------------------------------
  // Combinational helpers
  // ----------------------------------------------------------
  assign modrm      = (state == st_modrm_rd) ? din : modrm_q; // Live byte on read
  assign rd_size    = bitsize ? (pfx.osize ? sz32 : sz16) : sz8;
  assign mem_form   = (modrm_q[7:6] != 2'b11) && !pfx.asize;
  assign disp_ready = !(disp_present && !pfx.asize) || load_done;
  assign am         = (state == st_modrm_mem);
  assign address    = {am ? segment : sregs.cs, 4'h0} + {4'h0, am ? ea : ip};

  // Prefixes only count before 0Fh
  always_comb begin
    case (din)
      pfx_0f, pfx_es, pfx_cs, pfx_ss, pfx_ds,
      pfx_osize, pfx_asize, pfx_lock, pfx_fs, pfx_gs,
      pfx_repnz, pfx_repz: is_prefix = !opcode[8];
      default:             is_prefix = 1'b0;
    endcase
  end

  // Base plus displacement
  always_comb begin
    ea_calc = ea;
    if (!pfx.asize) begin
      case (modrm_q[7:6])
        2'b00:   if (modrm_q[2:0] == 3'b110) ea_calc = load_word[15:0]; // Direct
        2'b01:   ea_calc = ea + {{8{load_word[7]}}, load_word[7:0]};    // disp8
        2'b10:   ea_calc = ea + load_word[15:0];                        // disp16
        default: ea_calc = ea;
      endcase
    end
  end

  // Loader kick for displacement or memory operand
  always_comb begin
    load_start = 1'b0;
    load_size  = disp_size;
    if (state == st_modrm_rd) begin
      load_start = disp_present && !pfx.asize;
    end else if (state == st_modrm_op && disp_ready && mem_form) begin
      load_start = 1'b1;
      case (rd_size)
        sz8:     load_size = 2'd0;
        sz16:    load_size = 2'd1;
        default: load_size = 2'd3;
      endcase
    end
  end

  // ----------------------------------------------------------
  // State machine
  // ----------------------------------------------------------
  always_ff @(posedge clk25 or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_init;
      pfx       <= '0;
      opcode    <= '0;
      modrm_q   <= '0;
      has_modrm <= 1'b0;
      direction <= 1'b0;
      bitsize   <= 1'b0;
      ip        <= '0;
      segment   <= '0;
      ea        <= '0;
      ea_save   <= '0;
      op1       <= '0;
      op2       <= '0;
      rd_a      <= '0;
      rd_b      <= '0;
    end else begin
      if (load_byte) begin
        if (am) ea <= ea + 16'd1;        // Operand bytes walk ea
        else    ip <= ip + 16'd1;        // Displacement bytes walk ip
      end
      case (state)
        st_init: begin
          pfx       <= '0;
          opcode    <= '0;
          modrm_q   <= '0;
          has_modrm <= 1'b0;
          segment   <= sregs.ds;         // Default data segment
          ea        <= '0;
          op1       <= '0;               // Non-ModRM records carry zero operands
          op2       <= '0;
          state     <= st_fetch;
        end
        st_fetch: begin
          ip <= ip + 16'd1;
          if (is_prefix) begin
            case (din)
              pfx_0f: opcode[8] <= 1'b1;
              pfx_es: begin
                segment          <= sregs.es;
                pfx.seg_override <= 1'b1;
              end
              pfx_cs: begin
                segment          <= sregs.cs;
                pfx.seg_override <= 1'b1;
              end
              pfx_ss: begin
                segment          <= sregs.ss;
                pfx.seg_override <= 1'b1;
              end
              pfx_ds:    pfx.seg_override <= 1'b1; // Keeps ds and blocks the ss default
              pfx_osize: pfx.osize <= !pfx.osize;
              pfx_asize: pfx.asize <= !pfx.asize;
              pfx_repnz: pfx.repnz <= 1'b1;
              pfx_repz:  pfx.repz  <= 1'b1;
              default:   ;                 // lock, fs, gs
            endcase
          end else begin
            opcode[7:0] <= din;
            direction   <= din[1];
            bitsize     <= din[0];
            has_modrm   <= needs_modrm(din, opcode[8]);
            state       <= needs_modrm(din, opcode[8]) ? st_modrm_rd : st_issue;
          end
        end
        st_modrm_rd: begin
          ip      <= ip + 16'd1;
          modrm_q <= din;
          rd_a    <= din[2:0];
          rd_b    <= din[5:3];
          ea      <= base_ea;
          if (use_ss && !pfx.seg_override && !pfx.asize)
            segment <= sregs.ss;         // bp forms
          state   <= st_modrm_op;
        end
        st_modrm_op: begin
          if (disp_ready) begin          // Hold until disp assembled
            op1     <= direction ? val_b : val_a;
            op2     <= direction ? val_a : val_b;
            ea      <= ea_calc;
            ea_save <= ea_calc;
            state   <= mem_form ? st_modrm_mem : st_issue;
          end
        end
        st_modrm_mem: begin
          if (load_done) begin
            if (direction) op2 <= load_word; // reg, r/m
            else           op1 <= load_word; // r/m, reg
            ea    <= ea_save;              // Restore cycle
            state <= st_issue;
          end
        end
        st_issue: state <= st_init;
        default:  state <= st_init;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Decoded record
  // ----------------------------------------------------------
  assign dec_valid = (state == st_issue);

  always_comb begin
    dec             = '0;
    dec.opcode      = opcode;
    dec.modrm       = modrm_q;
    dec.has_modrm   = has_modrm;
    dec.mem_operand = has_modrm && mem_form;
    dec.addr32      = has_modrm && pfx.asize;
    dec.prefixes    = pfx;
    dec.segment     = segment;
    dec.ea          = ea;
    dec.op1         = op1;
    dec.op2         = op2;
    dec.ip_next     = ip;                // Points past the last byte
  end

endmodule

// File: fe_top.sv
`timescale 1ns/1ps

module fe_top (
  input  logic                       clk25,
  input  logic                       rst_n,
  input  x86_pkg::byte_t             din,        // Memory byte at address
  input  logic                       wb_valid,
  input  x86_pkg::wb_t               wb,
  output logic [x86_pkg::addr_w-1:0] address,
  output logic                       dec_valid,
  output x86_pkg::decoded_t          dec
);

  import x86_pkg::*;

  // Register file read side
  logic [2:0] rd_a;
  logic [2:0] rd_b;
  op_size_t   rd_size;
  word_t      val_a;
  word_t      val_b;
  sreg_t      sregs;
  half_t      bx;
  half_t      bp;
  half_t      si;
  half_t      di;

  // ModRM decode
  byte_t      modrm;
  half_t      base_ea;
  logic       use_ss;
  logic       disp_present;
  imm_size_t  disp_size;

  // Byte loader handshake
  logic       load_start;
  imm_size_t  load_size;
  logic       load_byte;
  logic       load_done;
  word_t      load_word;

  instr_sequencer u_seq (
    .clk25        (clk25),
    .rst_n        (rst_n),
    .din          (din),
    .rd_a         (rd_a),
    .rd_b         (rd_b),
    .rd_size      (rd_size),
    .val_a        (val_a),
    .val_b        (val_b),
    .sregs        (sregs),
    .modrm        (modrm),
    .base_ea      (base_ea),
    .use_ss       (use_ss),
    .disp_size    (disp_size),
    .disp_present (disp_present),
    .load_start   (load_start),
    .load_size    (load_size),
    .load_byte    (load_byte),
    .load_done    (load_done),
    .load_word    (load_word),
    .address      (address),
    .dec_valid    (dec_valid),
    .dec          (dec)
  );

  modrm_ea_unit u_ea (
    .modrm        (modrm),
    .bx           (bx),
    .bp           (bp),
    .si           (si),
    .di           (di),
    .base_ea      (base_ea),
    .use_ss       (use_ss),
    .disp_present (disp_present),
    .disp_size    (disp_size)
  );

  imm_loader u_imm (
    .clk25      (clk25),
    .rst_n      (rst_n),
    .din        (din),
    .load_start (load_start),
    .load_size  (load_size),
    .load_byte  (load_byte),
    .load_done  (load_done),
    .load_word  (load_word)
  );

  reg_file u_regs (
    .clk25    (clk25),
    .rst_n    (rst_n),
    .rd_a     (rd_a),
    .rd_b     (rd_b),
    .rd_size  (rd_size),
    .val_a    (val_a),
    .val_b    (val_b),
    .wb_valid (wb_valid),
    .wb       (wb),
    .sregs    (sregs),
    .bx       (bx),
    .bp       (bp),
    .si       (si),
    .di       (di)
  );

endmodule

// File: tb_mem_model.svh
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// ------------------------------------------------------------
// Memory, code builder and reference model
// ------------------------------------------------------------
byte_t       mem [0:1048575];            // Full 1 MB real-mode space
word_t       mreg [8];                   // eax..edi as the model sees them
half_t       mes;
half_t       mss;
half_t       mds;
logic [31:0] lfsr = 32'hff5b4a09;
int          pc;                         // Next code byte to emit
int          instr_ip;                   // First byte of current instruction

// Galois LFSR, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  logic        lsb;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lsb  = lfsr[0];
    lfsr = lfsr >> 1;
    if (lsb) lfsr = lfsr ^ 32'h80200003;
    v = {v[30:0], lsb};
  end
  return v;
endfunction

// Whole-address fill, so a wrong address shows up
function automatic byte_t fill_byte(input logic [19:0] a);
  return a[7:0] ^ a[15:8] ^ {4'h0, a[19:16]} ^ 8'h5a;
endfunction

// 1, 2 or 4 byte view of a register code
function automatic word_t reg_view(input logic [2:0] c, input int n);
  if (n == 4) return mreg[c];
  if (n == 2) return {16'h0000, mreg[c][15:0]};
  if (c[2])   return {24'h0, mreg[{1'b0, c[1:0]}][15:8]}; // AH..BH
  return {24'h0, mreg[c][7:0]};
endfunction

// Little-endian read, ea wraps at 64K
function automatic word_t read_le(input half_t seg, input half_t ea, input int n);
  word_t       v;
  half_t       off;
  logic [19:0] a;
  v = '0;
  for (int i = 0; i < n; i++) begin
    off = ea + i[15:0];
    a   = {seg, 4'h0} + {4'h0, off};
    v[8*i +: 8] = mem[a];
  end
  return v;
endfunction

task automatic put(input byte_t b);
  mem[pc] = b;
  pc++;
endtask

// NOP gap lets write-backs settle before the next instruction
task automatic begin_instr();
  repeat (12) put(8'h90);
  instr_ip = pc;
endtask

`endif

// File: tb_fe_top.sv
`timescale 1ns/1ps

module tb_fe_top;

  import x86_pkg::*;

  logic                clk25;
  logic                rst_n;
  byte_t               din;
  logic                wb_valid;
  wb_t                 wb;
  logic [addr_w-1:0]   address;
  logic                dec_valid;
  decoded_t            dec;
  int                  errors = 0;       // Wrong values
  int                  fails  = 0;       // Timeouts and protocol

  `include "tb_mem_model.svh"

  assign din = mem[address];             // Combinational memory

  fe_top i_dut (
    .clk25     (clk25),
    .rst_n     (rst_n),
    .din       (din),
    .wb_valid  (wb_valid),
    .wb        (wb),
    .address   (address),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  initial begin
    clk25 = 1'b0;
    forever #4 clk25 = ~clk25;
  end

  // Strobe is one cycle wide and quiet in reset
  assert property (@(posedge clk25) disable iff (!rst_n) dec_valid |=> !dec_valid)
    else begin
      fails++;
      $display("dec_valid stayed high for more than one cycle");
    end
  assert property (@(posedge clk25) !rst_n |-> !dec_valid)
    else begin
      fails++;
      $display("dec_valid went high during reset");
    end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else begin
        errors++;
        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      end
  endtask

  task automatic finish_run();
    $display("Closing report: %0d value errors, %0d other failures", errors, fails);
    if (errors == 0 && fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  // Skips the NOP gap and stops at the next real record
  task automatic wait_record(output logic ok);
    int n;
    n = 0;
    do begin
      @(negedge clk25);
      n++;
    end while (!(dec_valid && dec.opcode != 9'h090) && n < 400);
    ok = dec_valid && dec.opcode != 9'h090;
    if (!ok) begin
      fails++;
      $display("Timeout while waiting for a decoded record");
    end
  endtask

  // Emits n code bytes, most significant byte of code first
  task automatic emit_code(input int n, input logic [31:0] code);
    for (int i = n - 1; i >= 0; i--) begin
      put(code[8*i +: 8]);
    end
  endtask

  task automatic write_reg(input logic s, input logic [2:0] r, input op_size_t sz,
                           input word_t d);
    wb_t w;
    w.sreg = s;
    w.rnum = r;
    w.size = sz;
    w.data = d;
    @(posedge clk25);
    wb_valid <= 1'b1;
    wb       <= w;
    if (s) begin
      case (r[1:0])
        2'd0:    mes = d[15:0];
        2'd2:    mss = d[15:0];
        2'd3:    mds = d[15:0];
        default: ;                       // cs stays zero in this bench
      endcase
    end else if (sz == sz32) mreg[r] = d;
    else if (sz == sz16)     mreg[r][15:0] = d[15:0];
    else if (r[2])           mreg[{1'b0, r[1:0]}][15:8] = d[7:0];
    else                     mreg[r][7:0] = d[7:0];
  endtask

  task automatic wb_idle();
    @(posedge clk25);
    wb_valid <= 1'b0;
  endtask

  // Override code 0 none, 1 es, 2 cs, 3 ss
  task automatic expect_modrm(input byte_t opc, input logic ext, input byte_t m,
                              input logic osz, input int ovr, input half_t disp,
                              input logic rz, input logic rnz);
    int    nb;
    logic  mem_f;
    logic  bp_form;
    half_t ea;
    half_t seg;
    word_t regv;
    word_t rmv;
    logic  ok;
    nb      = !opc[0] ? 1 : (osz ? 4 : 2);
    mem_f   = (m[7:6] != 2'b11);
    bp_form = mem_f && (m[2:1] == 2'b01 || (m[2:0] == 3'b110 && m[7:6] != 2'b00));
    case (m[2:0])
      3'd0: ea = mreg[3][15:0] + mreg[6][15:0];
      3'd1: ea = mreg[3][15:0] + mreg[7][15:0];
      3'd2: ea = mreg[5][15:0] + mreg[6][15:0];
      3'd3: ea = mreg[5][15:0] + mreg[7][15:0];
      3'd4: ea = mreg[6][15:0];
      3'd5: ea = mreg[7][15:0];
      3'd6: ea = (m[7:6] == 2'b00) ? 16'h0000 : mreg[5][15:0];
      default: ea = mreg[3][15:0];
    endcase
    ea  = ea + disp;
    seg = (ovr == 1) ? mes : (ovr == 2) ? 16'h0000 : (ovr == 3) ? mss :
          bp_form ? mss : mds;
    regv = reg_view(m[5:3], nb);
    rmv  = mem_f ? read_le(seg, ea, nb) : reg_view(m[2:0], nb);
    wait_record(ok);
    if (ok) begin
      check_val("opcode", dec.opcode, {ext, opc});
      check_val("modrm", dec.modrm, m);
      check_val("has_modrm", dec.has_modrm, 1'b1);
      check_val("mem_operand", dec.mem_operand, mem_f);
      check_val("addr32", dec.addr32, 1'b0);
      check_val("prefixes", dec.prefixes, {osz, 1'b0, rz, rnz, ovr != 0});
      check_val("ip_next", dec.ip_next, pc);
      if (mem_f) begin
        check_val("segment", dec.segment, seg);
        check_val("ea", dec.ea, ea);
      end
      check_val("op1", dec.op1, opc[1] ? regv : rmv);
      check_val("op2", dec.op2, opc[1] ? rmv : regv);
    end
  endtask

  initial begin
    byte_t d8;
    half_t d16;
    logic  ok;
    rst_n    = 1'b0;
    wb_valid = 1'b0;
    wb       = '0;
    pc       = 0;
    for (int i = 0; i < 1048576; i++) mem[i] = fill_byte(i[19:0]);
    for (int i = 0; i < 8; i++) mreg[i] = '0;
    {mes, mss, mds} = '0;
    begin_instr();
    emit_code(2, 32'h00e5);                        // add ch, ah
    repeat (5) begin
      @(negedge clk25);
      check_val("address", address, 20'h0);
      check_val("dec_valid", dec_valid, 1'b0);
    end
    @(posedge clk25);
    rst_n <= 1'b1;
    // ----------------------------------------------------------
    // Register operands
    // ----------------------------------------------------------
    for (int r = 0; r < 8; r++) write_reg(1'b0, r[2:0], sz32, rand_bits(32));
    write_reg(1'b1, 3'd0, sz16, rand_bits(16));
    write_reg(1'b1, 3'd2, sz16, rand_bits(16));
    write_reg(1'b1, 3'd3, sz16, rand_bits(16));
    wb_idle();
    expect_modrm(8'h00, 1'b0, 8'he5, 1'b0, 0, 16'h0, 1'b0, 1'b0);
    begin_instr();
    emit_code(2, 32'h01d1);
    expect_modrm(8'h01, 1'b0, 8'hd1, 1'b0, 0, 16'h0, 1'b0, 1'b0);
    begin_instr();
    emit_code(3, 32'h6601d1);
    expect_modrm(8'h01, 1'b0, 8'hd1, 1'b1, 0, 16'h0, 1'b0, 1'b0);
    begin_instr();
    emit_code(4, 32'h666601d1);                    // 66h twice cancels
    expect_modrm(8'h01, 1'b0, 8'hd1, 1'b0, 0, 16'h0, 1'b0, 1'b0);
    begin_instr();
    emit_code(3, 32'h6603d1);                      // Direction bit set
    expect_modrm(8'h03, 1'b0, 8'hd1, 1'b1, 0, 16'h0, 1'b0, 1'b0);
    // ----------------------------------------------------------
    // Memory operands
    // ----------------------------------------------------------
    begin_instr();
    d8 = 8'(rand_bits(8)) | 8'h80;                 // Negative disp8
    emit_code(3, {8'h00, 8'h8b, 8'h40, d8});
    expect_modrm(8'h8b, 1'b0, 8'h40, 1'b0, 0, {{8{d8[7]}}, d8}, 1'b0, 1'b0);
    begin_instr();
    d8 = 8'(rand_bits(8));
    emit_code(4, {8'h66, 8'h8b, 8'h40, d8});
    expect_modrm(8'h8b, 1'b0, 8'h40, 1'b1, 0, {{8{d8[7]}}, d8}, 1'b0, 1'b0);
    for (int k = 0; k < 3; k++) begin              // bp+di+disp16 under ss, es and cs
      begin_instr();
      d16 = 16'(rand_bits(16));
      if (k == 1) put(8'h26);
      if (k == 2) put(8'h2e);
      emit_code(4, {8'h89, 8'h9b, d16[7:0], d16[15:8]});
      expect_modrm(8'h89, 1'b0, 8'h9b, 1'b0, k, d16, 1'b0, 1'b0);
    end
    for (int k = 0; k < 2; k++) begin              // Direct form under ds then ss
      begin_instr();
      d16 = 16'(rand_bits(16));
      if (k == 1) put(8'h36);
      emit_code(4, {8'h8a, 8'h06, d16[7:0], d16[15:8]});
      expect_modrm(8'h8a, 1'b0, 8'h06, 1'b0, k * 3, d16, 1'b0, 1'b0);
    end
    // ----------------------------------------------------------
    // Prefixes, classification, write-back
    // ----------------------------------------------------------
    begin_instr();
    emit_code(4, 32'hf30fafc1);
    expect_modrm(8'haf, 1'b1, 8'hc1, 1'b0, 0, 16'h0, 1'b1, 1'b0);
    begin_instr();
    emit_code(2, 32'hf2a4);                        // repnz movsb without ModRM
    wait_record(ok);
    if (ok) begin
      check_val("opcode", dec.opcode, 9'h0a4);
      check_val("has_modrm", dec.has_modrm, 1'b0);
      check_val("prefixes", dec.prefixes, 5'b00010);
      check_val("op1", dec.op1, 32'h0);
      check_val("op2", dec.op2, 32'h0);
      check_val("ip_next", dec.ip_next, instr_ip + 2);
    end
    begin_instr();
    emit_code(3, 32'h6601c8);                      // Full eax and ecx
    write_reg(1'b0, 3'd4, sz8, rand_bits(32));     // AH only
    write_reg(1'b0, 3'd1, sz16, rand_bits(32));    // cx only
    wb_idle();
    expect_modrm(8'h01, 1'b0, 8'hc8, 1'b1, 0, 16'h0, 1'b0, 1'b0);
    finish_run();
  end

endmodule

// File: verilog.f
+incdir+.
x86_pkg.sv
modrm_ea_unit.sv
imm_loader.sv
reg_file.sv
instr_sequencer.sv
fe_top.sv
tb_fe_top.sv

// File: Bender.yml
package:
  name: x86_fe

sources:
  - include_dirs:
      - .
    files:
      - x86_pkg.sv
      - modrm_ea_unit.sv
      - imm_loader.sv
      - reg_file.sv
      - instr_sequencer.sv
      - fe_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_fe_top.sv
